// File: build.f
verilog/spart_pkg.sv
verilog/spart_baud_gen.sv
verilog/spart_tx.sv
verilog/spart_rx.sv
verilog/spart_regs.sv
verilog/spart_top.sv
sim/spart_tb.sv

// File: sim/spart_tb.sv
// SPART testbench: APB register access, frame timing, busy handling and serial loopback
`timescale 1ns/1ps

module spart_tb
   import spart_pkg::*;
();

   // Small divisor keeps frames short
   localparam int DIV_VAL    = 4;
   localparam int BIT_CYCLES = DIV_VAL + 1;

   logic        clk;
   logic        rst_n;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        rxd;
   logic        txd;

   // Last APB read result and error flag
   logic [31:0] rd_data;
   logic        rd_err;
   logic [31:0] rng;
   int          cycle = 0;
   int          errors = 0;
   int          errors_at_start = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   spart_top #(
      .DIV_WIDTH (DIV_WIDTH_DEFAULT)
   ) dut_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .rxd     (rxd),
      .txd     (txd)
   );

   // Serial loopback
   assign rxd = txd;

   always #5 clk = ~clk;

   // Edge count, stable 1 ns after each rising edge
   always @(posedge clk)
      cycle <= cycle + 1;

   //////////////////////////////////////////////////
   // Checking
   //////////////////////////////////////////////////

   task note_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
      $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
   endtask

   task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else note_mismatch(name, got, exp);
   endtask

   // Start bit goes out on the strobe edge
   a_start_bit: assert property (@(posedge clk) disable iff (!rst_n) dut_i.trmt |=> !txd)
      else note_mismatch("txd", 32'($sampled(txd)), 32'h0);
   // Buffer goes busy on the same edge
   a_tx_busy: assert property (@(posedge clk) disable iff (!rst_n) dut_i.trmt |=> !dut_i.tx_done)
      else note_mismatch("tx_done", 32'($sampled(dut_i.tx_done)), 32'h0);
   a_pready: assert property (@(posedge clk) disable iff (!rst_n) (psel && penable) |-> pready)
      else note_mismatch("pready", 32'($sampled(pready)), 32'h1);
   // Error only in an access cycle
   a_pslverr: assert property (@(posedge clk) disable iff (!rst_n) pslverr |-> (psel && penable))
      else note_mismatch("pslverr", 32'($sampled(pslverr)), 32'h0);

   // xorshift32
   function automatic logic [31:0] next_rand(input logic [31:0] x);
      logic [31:0] v;
      v = x ^ (x << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   //////////////////////////////////////////////////
   // APB tasks, called and returning 1 ns after a rising edge
   //////////////////////////////////////////////////

   task apb_write(input logic [7:0] addr, input logic [31:0] data);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(posedge clk);
      #1;
      penable = 1'b1;
      // Mid access cycle
      @(negedge clk);
      rd_err = pslverr;
      check_value("pready", 32'(pready), 32'h1);
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task apb_read(input logic [7:0] addr);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      rd_data = prdata;
      rd_err  = pslverr;
      check_value("pready", 32'(pready), 32'h1);
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // Poll one STATUS bit until set
   task wait_status_bit(input int bit_idx, input string what);
      int polls;
      polls = 0;
      apb_read(ADDR_STATUS);
      while (rd_data[bit_idx] !== 1'b1 && polls < 100)
      begin
         apb_read(ADDR_STATUS);
         polls++;
      end
      if (rd_data[bit_idx] !== 1'b1)
      begin
         $display("ERROR timed out waiting for %s", what);
         errors++;
      end
   endtask

   task wait_cycle(input int target);
      int guard;
      guard = 0;
      while (cycle < target && guard < 200)
      begin
         @(posedge clk);
         #1;
         guard++;
      end
      if (cycle != target)
      begin
         $display("ERROR sample point at cycle %0d missed, now at cycle %0d", target, cycle);
         errors++;
      end
   endtask

   // Mid-bit txd samples; bit 0 is start, last is stop
   task check_frame(input int start_cycle, input logic [7:0] value, input int first_bit);
      logic exp_bit;
      for (int k = first_bit; k < FRAME_BITS; k++)
      begin
         if (k == 0)
            exp_bit = 1'b0;
         else if (k == FRAME_BITS - 1)
            exp_bit = 1'b1;
         else
            exp_bit = value[k-1];
         wait_cycle(start_cycle + k * BIT_CYCLES + BIT_CYCLES / 2);
         @(negedge clk);
         check_value("txd", 32'(txd), 32'(exp_bit));
      end
      @(posedge clk);
      #1;
   endtask

   task start_test;
      errors_at_start = errors;
   endtask

   task end_test(input string name);
      tests_run++;
      if (errors != errors_at_start)
      begin
         tests_failed++;
         $display("test %0d %s: fail", tests_run, name);
      end
      else
         $display("test %0d %s: ok", tests_run, name);
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial
   begin
      logic [7:0] byte_a;
      logic [7:0] byte_b;
      int         c0;
      clk     = 1'b0;
      rst_n   = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = 8'h00;
      pwdata  = 32'h0;
      rng     = 32'h0057bec5;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Idle line, ready, nothing received
      start_test();
      check_value("txd", 32'(txd), 32'h1);
      check_value("pslverr", 32'(pslverr), 32'h0);
      apb_read(ADDR_STATUS);
      check_value("status", rd_data, 32'h1);
      check_value("pslverr", 32'(rd_err), 32'h0);
      apb_read(ADDR_DIV);
      check_value("div", rd_data, 32'h10);
      end_test("reset state");

      start_test();
      apb_write(ADDR_DIV, 32'h0123);
      apb_read(ADDR_DIV);
      check_value("div", rd_data, 32'h0123);
      apb_write(ADDR_DIV, DIV_VAL);
      apb_read(ADDR_DIV);
      check_value("div", rd_data, DIV_VAL);
      check_value("pslverr", 32'(rd_err), 32'h0);
      // Unmapped offset
      apb_read(8'h0c);
      check_value("pslverr", 32'(rd_err), 32'h1);
      apb_write(8'h0c, 32'h5a);
      check_value("pslverr", 32'(rd_err), 32'h1);
      apb_read(ADDR_DIV);
      check_value("div", rd_data, DIV_VAL);
      end_test("register access");

      start_test();
      for (int i = 0; i < 2; i++)
      begin
         rng    = next_rand(rng);
         byte_a = rng[7:0];
         wait_status_bit(0, "transmit buffer ready");
         apb_write(ADDR_DATA, 32'(byte_a));
         c0 = cycle;
         check_value("txd", 32'(txd), 32'h0);
         check_frame(c0, byte_a, 0);
         // Consume the looped-back byte so rda starts clear later
         wait_status_bit(1, "receive data available");
         apb_read(ADDR_DATA);
      end
      end_test("frame format");

      start_test();
      wait_status_bit(0, "transmit buffer ready");
      rng    = next_rand(rng);
      byte_a = rng[7:0];
      byte_b = ~byte_a;
      apb_write(ADDR_DATA, 32'(byte_a));
      c0 = cycle;
      apb_read(ADDR_STATUS);
      check_value("tbr", 32'(rd_data[0]), 32'h0);
      // Dropped, frame on the line stays byte_a
      apb_write(ADDR_DATA, 32'(byte_b));
      check_frame(c0, byte_a, 1);
      wait_cycle(c0 + FRAME_BITS * BIT_CYCLES);
      apb_read(ADDR_STATUS);
      check_value("tbr", 32'(rd_data[0]), 32'h1);
      // Looped-back copy must be byte_a too
      wait_status_bit(1, "receive data available");
      apb_read(ADDR_DATA);
      check_value("rx data", rd_data, 32'(byte_a));
      apb_read(ADDR_STATUS);
      check_value("rda", 32'(rd_data[1]), 32'h0);
      end_test("busy handling");

      start_test();
      for (int i = 0; i < 4; i++)
      begin
         rng    = next_rand(rng);
         byte_a = rng[7:0];
         wait_status_bit(0, "transmit buffer ready");
         apb_write(ADDR_DATA, 32'(byte_a));
         wait_status_bit(1, "receive data available");
         apb_read(ADDR_DATA);
         check_value("rx data", rd_data, 32'(byte_a));
         // DATA read clears rda
         apb_read(ADDR_STATUS);
         check_value("rda", 32'(rd_data[1]), 32'h0);
      end
      end_test("loopback receive");

      $display("ran %0d tests, %0d failing, %0d check errors", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

// File: verilog/spart_baud_gen.sv
// SPART baud generator: programmable down-counter giving one tick per bit period
`timescale 1ns/1ps

module spart_baud_gen
   import spart_pkg::*;
#(
   parameter int DIV_WIDTH = DIV_WIDTH_DEFAULT
)
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [DIV_WIDTH-1:0] divisor,
   input  logic                 trmt,
   output logic                 baud_full
);

   //////////////////////////////////////////////////
   // Period counter
   //////////////////////////////////////////////////

   // Counts divisor down to zero, so divisor+1 clocks per bit
   logic [DIV_WIDTH-1:0] cnt;

   // Tick on expiry
   assign baud_full = (cnt == '0);

   // Starts at all ones so no tick right after reset
   // Transmit strobe realigns the period to the frame start
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cnt <= '1;
      end
      else if (trmt || baud_full)
      begin
         // Reload for the next bit
         cnt <= divisor;
      end
      else
      begin
         cnt <= cnt - 1'b1;
      end
   end

endmodule

// File: verilog/spart_pkg.sv
// SPART shared definitions: register map, status and receive structs, frame constants

package spart_pkg;

   //////////////////////////////////////////////////
   // Frame and divisor
   //////////////////////////////////////////////////

   // Default baud divisor width
   localparam int DIV_WIDTH_DEFAULT = 16;

   // Start bit, eight data bits, one stop bit
   localparam int FRAME_BITS = 10;

   //////////////////////////////////////////////////
   // APB register map
   //////////////////////////////////////////////////

   localparam logic [7:0] ADDR_DATA   = 8'h00;
   localparam logic [7:0] ADDR_STATUS = 8'h04;
   localparam logic [7:0] ADDR_DIV    = 8'h08;

   // Divisor value out of reset
   localparam logic [15:0] DIV_RESET = 16'h0010;

   // Status word, tbr lands in bit 0
   typedef struct packed {
      logic rda;
      logic tbr;
   } spart_status_t;

   // Received byte with its available flag
   typedef struct packed {
      logic       valid;
      logic [7:0] data;
   } spart_rx_t;

endpackage

// File: verilog/spart_regs.sv
// SPART APB register block: divisor, transmit strobe, received data and status
`timescale 1ns/1ps

module spart_regs
   import spart_pkg::*;
#(
   parameter int DIV_WIDTH = DIV_WIDTH_DEFAULT
)
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  logic [7:0]           paddr,
   input  logic [31:0]          pwdata,
   output logic [31:0]          prdata,
   output logic                 pready,
   output logic                 pslverr,
   input  logic                 tx_done,
   input  spart_rx_t            rx,
   output logic                 trmt,
   output logic [7:0]           tx_data,
   output logic [DIV_WIDTH-1:0] divisor,
   output logic                 rx_ack
);

   logic          access;
   logic          wr_en;
   logic          rd_en;
   logic          sel_data;
   logic          sel_status;
   logic          sel_div;
   spart_status_t status;

   //////////////////////////////////////////////////
   // APB decode
   //////////////////////////////////////////////////

   // Access cycle only, no wait states
   assign access = psel & penable;
   assign wr_en  = access & pwrite;
   assign rd_en  = access & ~pwrite;
   assign pready = 1'b1;

   assign sel_data   = (paddr == ADDR_DATA);
   assign sel_status = (paddr == ADDR_STATUS);
   assign sel_div    = (paddr == ADDR_DIV);

   // Error on anything outside the map
   assign pslverr = access & ~(sel_data | sel_status | sel_div);

   //////////////////////////////////////////////////
   // Transmit and receive handshakes
   //////////////////////////////////////////////////

   // Write to DATA while busy is dropped
   assign trmt    = wr_en & sel_data & tx_done;
   // Shifter captures the byte on the strobe
   assign tx_data = pwdata[7:0];
   // Reading DATA consumes the byte
   assign rx_ack  = rd_en & sel_data;

   //////////////////////////////////////////////////
   // Divisor register
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         divisor <= DIV_WIDTH'(DIV_RESET);
      else if (wr_en && sel_div)
         divisor <= pwdata[DIV_WIDTH-1:0];
   end

   //////////////////////////////////////////////////
   // Read mux
   //////////////////////////////////////////////////

   assign status.tbr = tx_done;
   assign status.rda = rx.valid;

   always_comb
   begin
      prdata = '0;
      if (rd_en)
      begin
         if (sel_data)
            prdata = {24'h0, rx.data};
         else if (sel_status)
            prdata = {30'h0, status};
         else if (sel_div)
            prdata = 32'(divisor);
      end
   end

endmodule

// File: verilog/spart_rx.sv
// SPART receiver: start detection, mid-bit sampling and a one-byte holding register
`timescale 1ns/1ps

module spart_rx
   import spart_pkg::*;
#(
   parameter int DIV_WIDTH = DIV_WIDTH_DEFAULT
)
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 rxd,
   input  logic [DIV_WIDTH-1:0] divisor,
   input  logic                 rx_ack,
   output spart_rx_t            rx
);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_SHIFT} rx_state_t;

   localparam int CNT_W = $clog2(FRAME_BITS);

   rx_state_t            state;
   rx_state_t            nxt_state;
   logic                 rxd_meta;
   logic                 rxd_sync;
   logic                 rxd_prev;
   logic                 start_edge;
   logic [DIV_WIDTH-1:0] period_cnt;
   logic                 sample;
   logic [CNT_W-1:0]     bit_cnt;
   logic                 last_bit;
   logic                 frame_done;
   logic [7:0]           shift_reg;
   logic                 rx_valid;
   logic [7:0]           rx_data;

   //////////////////////////////////////////////////
   // Input synchronizer and edge detect
   //////////////////////////////////////////////////

   // Idle line is high
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
      end
      else
      begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
      end
   end

   assign start_edge = rxd_prev & ~rxd_sync;

   //////////////////////////////////////////////////
   // Sample timing
   //////////////////////////////////////////////////

   // Half period in idle, full period after each sample
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         period_cnt <= '0;
      else if (state == RX_IDLE)
         period_cnt <= divisor >> 1;
      else if (sample)
         period_cnt <= divisor;
      else
         period_cnt <= period_cnt - 1'b1;
   end

   assign sample     = (period_cnt == '0);
   // Ninth sample after start is the stop bit
   assign last_bit   = (bit_cnt == CNT_W'(FRAME_BITS - 2));
   assign frame_done = (state == RX_SHIFT) & sample & last_bit;

   //////////////////////////////////////////////////
   // State machine
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= RX_IDLE;
      else
         state <= nxt_state;
   end

   always_comb
   begin
      nxt_state = state;
      case (state)
         RX_IDLE:
            if (start_edge)
               nxt_state = RX_START;
         RX_START:
            // Glitch shorter than half a bit goes back to idle
            if (sample)
               nxt_state = rxd_sync ? RX_IDLE : RX_SHIFT;
         RX_SHIFT:
            if (frame_done)
               nxt_state = RX_IDLE;
         default:
            nxt_state = RX_IDLE;
      endcase
   end

   // Data bits arrive LSB first
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         bit_cnt <= '0;
      else if (state != RX_SHIFT)
         bit_cnt <= '0;
      else if (sample)
         bit_cnt <= bit_cnt + 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (state == RX_SHIFT && sample && !last_bit)
         shift_reg <= {rxd_sync, shift_reg[7:1]};
   end

   //////////////////////////////////////////////////
   // Holding register
   //////////////////////////////////////////////////

   // Low stop bit drops the frame; new byte wins over ack
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         rx_valid <= 1'b0;
      else if (frame_done && rxd_sync)
         rx_valid <= 1'b1;
      else if (rx_ack)
         rx_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (frame_done && rxd_sync)
         rx_data <= shift_reg;
   end

   assign rx.valid = rx_valid;
   assign rx.data  = rx_data;

endmodule

// File: verilog/spart_top.sv
// SPART top level: APB register block, baud generator, transmitter and receiver
`timescale 1ns/1ps

module spart_top
   import spart_pkg::*;
#(
   parameter int DIV_WIDTH = DIV_WIDTH_DEFAULT
)
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [7:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   input  logic        rxd,
   output logic        txd
);

   // Register block side
   logic                 trmt;
   logic [7:0]           tx_data;
   logic [DIV_WIDTH-1:0] divisor;
   logic                 rx_ack;
   // Serial engine side
   logic                 baud_full;
   logic                 tx_done;
   spart_rx_t            rx;

   spart_regs #(
      .DIV_WIDTH (DIV_WIDTH)
   ) u_regs (
      .clk     (clk),
      .rst_n   (rst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .tx_done (tx_done),
      .rx      (rx),
      .trmt    (trmt),
      .tx_data (tx_data),
      .divisor (divisor),
      .rx_ack  (rx_ack)
   );

   //////////////////////////////////////////////////
   // Transmit path
   //////////////////////////////////////////////////

   spart_baud_gen #(
      .DIV_WIDTH (DIV_WIDTH)
   ) u_baud_gen (
      .clk       (clk),
      .rst_n     (rst_n),
      .divisor   (divisor),
      .trmt      (trmt),
      .baud_full (baud_full)
   );

   spart_tx u_tx (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_data   (tx_data),
      .trmt      (trmt),
      .baud_full (baud_full),
      .tx_out    (txd),
      .tx_done   (tx_done)
   );

   //////////////////////////////////////////////////
   // Receive path
   //////////////////////////////////////////////////

   // Own period timing from the same divisor
   spart_rx #(
      .DIV_WIDTH (DIV_WIDTH)
   ) u_rx (
      .clk     (clk),
      .rst_n   (rst_n),
      .rxd     (rxd),
      .divisor (divisor),
      .rx_ack  (rx_ack),
      .rx      (rx)
   );

endmodule

// File: verilog/spart_tx.sv
// SPART transmitter: loads a byte on the strobe and shifts out an 8N1 frame
`timescale 1ns/1ps

module spart_tx
   import spart_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic [7:0] in_data,
   input  logic       trmt,
   input  logic       baud_full,
   output logic       tx_out,
   output logic       tx_done
);

   typedef enum logic {TX_IDLE, TX_SEND} tx_state_t;

   localparam int CNT_W = $clog2(FRAME_BITS);

   tx_state_t        state;
   tx_state_t        nxt_state;
   logic [8:0]       shift_reg;
   logic [CNT_W-1:0] bit_cntr;
   logic             in_transmit;
   logic             bit_tick;
   logic             frame_end;

   // One shift per baud tick, only while sending
   assign bit_tick  = in_transmit & baud_full;
   // Tenth tick closes the frame
   assign frame_end = bit_tick & (bit_cntr == CNT_W'(FRAME_BITS - 1));

   //////////////////////////////////////////////////
   // Bit counter
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         bit_cntr <= '0;
      else if (trmt)
         bit_cntr <= '0;
      else if (bit_tick)
         bit_cntr <= bit_cntr + 1'b1;
   end

   //////////////////////////////////////////////////
   // Shifter
   //////////////////////////////////////////////////

   // Byte plus start bit in bit 0, ones fill from the top as stop/idle
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         shift_reg <= 9'h1ff;
      else if (trmt)
         shift_reg <= {in_data, 1'b0};
      else if (bit_tick)
         shift_reg <= {1'b1, shift_reg[8:1]};
   end

   assign tx_out = shift_reg[0];

   //////////////////////////////////////////////////
   // State machine
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= TX_IDLE;
      else
         state <= nxt_state;
   end

   always_comb
   begin
      // Defaults
      nxt_state   = state;
      in_transmit = 1'b0;
      case (state)
         TX_IDLE:
            if (trmt)
               nxt_state = TX_SEND;
         TX_SEND:
         begin
            in_transmit = 1'b1;
            if (frame_end)
               nxt_state = TX_IDLE;
         end
         default:
            nxt_state = TX_IDLE;
      endcase
   end

   // Buffer busy from strobe until the frame is out
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         tx_done <= 1'b1;
      else if (trmt)
         tx_done <= 1'b0;
      else if (frame_end)
         tx_done <= 1'b1;
   end

endmodule
